//--- build.f
common/wb_pkg.sv
common/br_pkg.sv
common/br_issue_if.sv
hw/branch_rs/tag_wakeup.sv
hw/branch_rs/branch_rs.sv
hw/phys_regfile.sv
hw/branch_resolve.sv
hw/branch_unit_top.sv
testbench/branch_unit_props.sv
testbench/branch_checker.sv
testbench/tb_branch_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_branch_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_branch_unit.sv
`timescale 1ns/1ps

module tb_branch_unit;

  localparam int DEPTH  = 16;
  localparam int NUM_WB = 3;

  logic                          clk;
  logic                          rst;
  logic                          flush;
  logic                          disp_valid;
  logic [2:0]                    disp_op;
  wb_pkg::xlen_t                 disp_pc;
  wb_pkg::xlen_t                 disp_imm;
  wb_pkg::tag_t                  disp_src1_tag;
  wb_pkg::tag_t                  disp_src2_tag;
  logic                          disp_src1_rdy;
  logic                          disp_src2_rdy;
  wb_pkg::tag_t                  disp_dest_tag;
  logic                          disp_pred_taken;
  logic                          disp_pred_hit;
  logic [31:0]                   disp_inst_num;
  logic [NUM_WB-1:0]             wb_valid;
  wb_pkg::tag_t [NUM_WB-1:0]     wb_tag;
  wb_pkg::xlen_t [NUM_WB-1:0]    wb_data;
  logic                          rs_full;
  logic                          res_valid;
  logic                          res_taken;
  logic                          res_mispredict;
  wb_pkg::xlen_t                 res_target;
  wb_pkg::xlen_t                 res_link;
  wb_pkg::tag_t                  res_dest_tag;
  logic [31:0]                   res_inst_num;

  logic [31:0]  lfsr_state = 32'h1daf981f;
  logic [31:0]  extremes [4] = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
  wb_pkg::tag_t pend_q[$];  // fresh tags still to broadcast
  int           tb_errors = 0;
  int           inst_ctr = 0;
  int           fresh_tag;
  bit           timed_out = 0;

  branch_unit_top #(.DEPTH(DEPTH), .NUM_WB(NUM_WB)) i_dut (.*);

  branch_checker #(.NUM_WB(NUM_WB)) i_checker (
    .clk(clk), .rst(rst), .flush(flush), .disp_valid(disp_valid), .disp_op(disp_op),
    .disp_pc(disp_pc), .disp_imm(disp_imm), .disp_src1_tag(disp_src1_tag),
    .disp_src2_tag(disp_src2_tag), .disp_dest_tag(disp_dest_tag),
    .disp_pred_taken(disp_pred_taken), .disp_pred_hit(disp_pred_hit),
    .disp_inst_num(disp_inst_num), .rs_full(rs_full), .wb_valid(wb_valid), .wb_tag(wb_tag),
    .wb_data(wb_data), .res_valid(res_valid), .res_taken(res_taken),
    .res_mispredict(res_mispredict), .res_target(res_target), .res_link(res_link),
    .res_dest_tag(res_dest_tag), .res_inst_num(res_inst_num)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] pick_value();
    if (next_bits(2) == 0) return extremes[next_bits(2)];  // signed/unsigned corners
    return next_bits(32);
  endfunction

  task automatic wait_not_full();
    int n;
    n = 0;
    while (rs_full && !timed_out) begin
      @(negedge clk);
      n++;
      if (n > 200) begin
        $display("timeout waiting for the station to leave full at %0t", $time);
        timed_out = 1;
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (i_checker.pending_count != 0 && !timed_out) begin
      @(negedge clk);
      n++;
      if (n > 500) begin
        $display("timeout, dispatched branches never resolved at %0t", $time);
        timed_out = 1;
      end
    end
    repeat (3) @(negedge clk);
  endtask

  // old tags are ready and fresh ones get a bypass broadcast or wait in pend_q
  task automatic pick_source(output wb_pkg::tag_t tag, output logic rdy, inout int lane);
    logic [31:0] r;
    if (next_bits(1) == 1) begin
      r   = next_bits(5);
      tag = {1'b0, r[4:0]};
      rdy = 1'b1;
    end else begin
      tag = wb_pkg::tag_t'(fresh_tag);
      rdy = 1'b0;
      fresh_tag++;
      if (next_bits(2) == 0) begin
        wb_valid[lane] = 1'b1;
        wb_tag[lane]   = tag;
        wb_data[lane]  = pick_value();
        lane           = (lane + 1) % NUM_WB;
      end else begin
        pend_q.push_back(tag);
      end
    end
  endtask

  task automatic drive_dispatch(input logic [2:0] op);
    logic [31:0] r;
    disp_valid      = 1'b1;
    disp_op         = op;
    r               = next_bits(30);
    disp_pc         = {r[29:0], 2'b00};
    r               = next_bits(12);
    disp_imm        = {{19{r[11]}}, r[11:0], 1'b0};
    r               = next_bits(6);
    disp_dest_tag   = r[5:0];
    disp_pred_taken = next_bits(1) == 1;
    disp_pred_hit   = next_bits(2) != 0;
    disp_inst_num   = inst_ctr;
    inst_ctr++;
  endtask

  task automatic load_regs();
    for (int t = 0; t < 64; t += NUM_WB) begin
      for (int w = 0; w < NUM_WB; w++) begin
        wb_valid[w] = (t + w) < 64;
        wb_tag[w]   = wb_pkg::tag_t'(t + w);
        wb_data[w]  = (t + w < 4) ? extremes[t + w] : pick_value();
      end
      @(negedge clk);
    end
    wb_valid = '0;
  endtask

  task automatic run_round();
    int          n;
    int          lane;
    int          k;
    logic [31:0] r;
    n         = 1 + int'(next_bits(3)) % 6;
    fresh_tag = 32;
    for (int i = 0; i < n; i++) begin
      wait_not_full();
      if (timed_out) return;
      r    = next_bits(2);
      lane = int'(r) % NUM_WB;
      pick_source(disp_src1_tag, disp_src1_rdy, lane);
      pick_source(disp_src2_tag, disp_src2_rdy, lane);
      r = next_bits(3);
      drive_dispatch(r[2:0]);
      flush = next_bits(4) == 0;  // occasional external flush
      @(negedge clk);
      disp_valid = 1'b0;
      flush      = 1'b0;
      wb_valid   = '0;
      if (next_bits(1) == 1) @(negedge clk);
    end
    // late wakeups in shuffled order let heads block younger ready entries
    while (pend_q.size() > 0) begin
      for (int w = 0; w < NUM_WB; w++) begin
        if (pend_q.size() > 0 && (w == 0 || next_bits(1) == 1)) begin
          k           = int'(next_bits(4)) % pend_q.size();
          wb_valid[w] = 1'b1;
          wb_tag[w]   = pend_q[k];
          wb_data[w]  = pick_value();
          pend_q.delete(k);
        end
      end
      @(negedge clk);
      wb_valid = '0;
    end
    wait_drain();
  endtask

  task automatic fill_and_flush();
    for (int i = 0; i < DEPTH; i++) begin
      disp_src1_tag = 6'd63;  // left unready so the head stays blocked
      disp_src1_rdy = 1'b0;
      disp_src2_tag = 6'd5;
      disp_src2_rdy = 1'b1;
      drive_dispatch(3'b000);
      @(negedge clk);
    end
    disp_valid = 1'b0;
    if (rs_full !== 1'b1) begin
      $display("** Error at %0t: rs_full got %b expected %b", $time, rs_full, 1'b1);
      tb_errors++;
    end
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    if (rs_full !== 1'b0) begin
      $display("** Error at %0t: rs_full got %b expected %b", $time, rs_full, 1'b0);
      tb_errors++;
    end
    wb_valid[0] = 1'b1;  // late wakeup must not revive flushed entries
    wb_tag[0]   = 6'd63;
    wb_data[0]  = pick_value();
    @(negedge clk);
    wb_valid = '0;
    repeat (8) @(negedge clk);
    wait_drain();
  endtask

  initial begin
    rst             = 1'b1;
    flush           = 1'b0;
    disp_valid      = 1'b0;
    disp_op         = '0;
    disp_pc         = '0;
    disp_imm        = '0;
    disp_src1_tag   = '0;
    disp_src2_tag   = '0;
    disp_src1_rdy   = 1'b0;
    disp_src2_rdy   = 1'b0;
    disp_dest_tag   = '0;
    disp_pred_taken = 1'b0;
    disp_pred_hit   = 1'b0;
    disp_inst_num   = '0;
    wb_valid        = '0;
    wb_tag          = '0;
    wb_data         = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    load_regs();
    for (int r = 0; r < 60 && !timed_out; r++) run_round();
    if (!timed_out) fill_and_flush();
    for (int r = 0; r < 10 && !timed_out; r++) run_round();
    $display("results checked %0d, value errors %0d, other errors %0d, timeout %0d",
             i_checker.checked_count, i_checker.error_count, tb_errors, timed_out);
    if (timed_out || tb_errors != 0 || i_checker.error_count != 0 ||
        i_checker.checked_count == 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule

//--- testbench/branch_checker.sv
`timescale 1ns/1ps

module branch_checker #(
  parameter int NUM_WB = 3
) (
  input logic                          clk,
  input logic                          rst,
  input logic                          flush,
  input logic                          disp_valid,
  input logic [2:0]                    disp_op,
  input wb_pkg::xlen_t                 disp_pc,
  input wb_pkg::xlen_t                 disp_imm,
  input wb_pkg::tag_t                  disp_src1_tag,
  input wb_pkg::tag_t                  disp_src2_tag,
  input wb_pkg::tag_t                  disp_dest_tag,
  input logic                          disp_pred_taken,
  input logic                          disp_pred_hit,
  input logic [31:0]                   disp_inst_num,
  input logic                          rs_full,
  input logic [NUM_WB-1:0]             wb_valid,
  input wb_pkg::tag_t [NUM_WB-1:0]     wb_tag,
  input wb_pkg::xlen_t [NUM_WB-1:0]    wb_data,
  input logic                          res_valid,
  input logic                          res_taken,
  input logic                          res_mispredict,
  input wb_pkg::xlen_t                 res_target,
  input wb_pkg::xlen_t                 res_link,
  input wb_pkg::tag_t                  res_dest_tag,
  input logic [31:0]                   res_inst_num
);

  typedef struct {
    logic [2:0]   op;
    logic [31:0]  pc;
    logic [31:0]  imm;
    wb_pkg::tag_t src1;
    wb_pkg::tag_t src2;
    wb_pkg::tag_t dest;
    logic         pred_taken;
    logic         pred_hit;
    logic [31:0]  num;
  } branch_t;

  branch_t     exp_q[$];  // accepted and unresolved in dispatch order
  logic [31:0] regs_model [64];
  int          error_count = 0;
  int          checked_count = 0;
  int          pending_count = 0;

  function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
    if (a[31] != b[31]) return a[31];  // negative side is smaller
    return a < b;
  endfunction

  // returns {taken, mispredict, target, link}
  function automatic logic [65:0] expected_result(input branch_t br, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic        taken;
    logic        mispredict;
    logic [31:0] target;
    case (br_pkg::br_op_e'(br.op))
      br_pkg::OP_BEQ:  taken = (a == b);
      br_pkg::OP_BNE:  taken = (a != b);
      br_pkg::OP_BLT:  taken = signed_less(a, b);
      br_pkg::OP_BGE:  taken = !signed_less(a, b);
      br_pkg::OP_BLTU: taken = (a < b);
      br_pkg::OP_BGEU: taken = !(a < b);
      default:         taken = 1'b1;
    endcase
    if (br.op == 3'b011) target = (a + br.imm) & 32'hffff_fffe;  // register jump
    else target = br.pc + br.imm;
    // a taken branch also needs a btb hit
    if (taken) mispredict = !br.pred_taken || !br.pred_hit;
    else mispredict = br.pred_taken;
    return {taken, mispredict, target, br.pc + 32'd4};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    branch_t     br;
    logic [65:0] exp;
    logic        kill;
    kill = 1'b0;
    if (rst) begin
      exp_q.delete();
    end else begin
      if (res_valid) begin
        if (exp_q.size() == 0) begin
          $display("result for inst %0d arrived with no branch pending at %0t",
                   res_inst_num, $time);
          error_count++;
        end else begin
          br   = exp_q.pop_front();
          exp  = expected_result(br, regs_model[br.src1], regs_model[br.src2]);
          kill = exp[64];  // expected mispredict empties the station
          check_value("res_inst_num", res_inst_num, br.num);
          check_value("res_taken", {31'b0, res_taken}, {31'b0, exp[65]});
          check_value("res_mispredict", {31'b0, res_mispredict}, {31'b0, exp[64]});
          check_value("res_target", res_target, exp[63:32]);
          check_value("res_link", res_link, exp[31:0]);
          check_value("res_dest_tag", {26'b0, res_dest_tag}, {26'b0, br.dest});
          checked_count++;
        end
      end
      // station clear drops queued entries and this cycle's dispatch
      if (flush || kill) begin
        exp_q.delete();
      end else if (disp_valid && !rs_full) begin
        exp_q.push_back('{disp_op, disp_pc, disp_imm, disp_src1_tag, disp_src2_tag,
                          disp_dest_tag, disp_pred_taken, disp_pred_hit, disp_inst_num});
      end
      for (int w = 0; w < NUM_WB; w++) begin
        if (wb_valid[w]) regs_model[wb_tag[w]] = wb_data[w];  // higher lane wins
      end
    end
    pending_count = exp_q.size();
  end

endmodule

//--- testbench/branch_unit_props.sv
`timescale 1ns/1ps

module branch_unit_props #(
  parameter int DEPTH = 16
) (
  input logic                     clk,
  input logic                     rst,
  input logic                     clear,
  input logic                     disp_valid,
  input logic                     full,
  input logic                     issue_valid,
  input logic [$clog2(DEPTH):0]   count
);

  localparam int CNT_W = $clog2(DEPTH) + 1;

  // dispatcher must honour the level full output
  no_dispatch_when_full: assert property (
    @(posedge clk) disable iff (rst) !(disp_valid && full)
  ) else $error("dispatch while the station is full");

  // nothing issues while clearing and the station is empty right after
  no_issue_through_clear: assert property (
    @(posedge clk) disable iff (rst)
      clear |-> !issue_valid ##1 (!issue_valid && (count == '0))
  ) else $error("issue or queued entries left behind by a station clear");

  count_within_depth: assert property (
    @(posedge clk) disable iff (rst) count <= CNT_W'(DEPTH)
  ) else $error("occupancy count above station depth");

endmodule

bind branch_rs branch_unit_props #(
  .DEPTH (DEPTH)
) i_props (
  .clk         (clk),
  .rst         (rst),
  .clear       (clear),
  .disp_valid  (disp_valid),
  .full        (full),
  .issue_valid (issue.valid),
  .count       (count_q)
);

//--- hw/branch_unit_top.sv
`timescale 1ns/1ps

module branch_unit_top #(
  parameter int DEPTH  = 16,
  parameter int NUM_WB = 3
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          flush,        // exception or trap return
  input  logic                          disp_valid,
  input  logic [br_pkg::OP_W-1:0]       disp_op,
  input  wb_pkg::xlen_t                 disp_pc,
  input  wb_pkg::xlen_t                 disp_imm,
  input  wb_pkg::tag_t                  disp_src1_tag,
  input  wb_pkg::tag_t                  disp_src2_tag,
  input  logic                          disp_src1_rdy,
  input  logic                          disp_src2_rdy,
  input  wb_pkg::tag_t                  disp_dest_tag,
  input  logic                          disp_pred_taken,
  input  logic                          disp_pred_hit,
  input  logic [br_pkg::INST_NUM_W-1:0] disp_inst_num,
  input  logic [NUM_WB-1:0]             wb_valid,
  input  wb_pkg::tag_t [NUM_WB-1:0]     wb_tag,
  input  wb_pkg::xlen_t [NUM_WB-1:0]    wb_data,
  output logic                          rs_full,
  output logic                          res_valid,
  output logic                          res_taken,
  output logic                          res_mispredict,
  output wb_pkg::xlen_t                 res_target,
  output wb_pkg::xlen_t                 res_link,
  output wb_pkg::tag_t                  res_dest_tag,
  output logic [br_pkg::INST_NUM_W-1:0] res_inst_num
);

  br_issue_if issue_bus ();

  logic          rs_clear;
  wb_pkg::tag_t  rd_tag1;
  wb_pkg::tag_t  rd_tag2;
  wb_pkg::xlen_t rd_data1;
  wb_pkg::xlen_t rd_data2;

  // a resolved mispredict kills everything younger in the station
  assign rs_clear = flush || (res_valid && res_mispredict);

  branch_rs #(
    .DEPTH  (DEPTH),
    .NUM_WB (NUM_WB)
  ) i_branch_rs (
    .clk             (clk),
    .rst             (rst),
    .clear           (rs_clear),
    .disp_valid      (disp_valid),
    .disp_op         (disp_op),
    .disp_pc         (disp_pc),
    .disp_imm        (disp_imm),
    .disp_src1_tag   (disp_src1_tag),
    .disp_src2_tag   (disp_src2_tag),
    .disp_src1_rdy   (disp_src1_rdy),
    .disp_src2_rdy   (disp_src2_rdy),
    .disp_dest_tag   (disp_dest_tag),
    .disp_pred_taken (disp_pred_taken),
    .disp_pred_hit   (disp_pred_hit),
    .disp_inst_num   (disp_inst_num),
    .wb_valid        (wb_valid),
    .wb_tag          (wb_tag),
    .full            (rs_full),
    .issue           (issue_bus.station)
  );

  phys_regfile #(
    .NUM_WB (NUM_WB)
  ) i_phys_regfile (
    .clk      (clk),
    .wb_valid (wb_valid),
    .wb_tag   (wb_tag),
    .wb_data  (wb_data),
    .rd_tag1  (rd_tag1),
    .rd_tag2  (rd_tag2),
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2)
  );

  branch_resolve i_branch_resolve (
    .clk            (clk),
    .rst            (rst),
    .issue          (issue_bus.resolver),
    .rs1_data       (rd_data1),
    .rs2_data       (rd_data2),
    .rd_tag1        (rd_tag1),
    .rd_tag2        (rd_tag2),
    .res_valid      (res_valid),
    .res_taken      (res_taken),
    .res_mispredict (res_mispredict),
    .res_target     (res_target),
    .res_link       (res_link),
    .res_dest_tag   (res_dest_tag),
    .res_inst_num   (res_inst_num)
  );

endmodule

//--- hw/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
  input  logic                          clk,
  input  logic                          rst,
  br_issue_if.resolver                  issue,
  input  wb_pkg::xlen_t                 rs1_data,
  input  wb_pkg::xlen_t                 rs2_data,
  output wb_pkg::tag_t                  rd_tag1,
  output wb_pkg::tag_t                  rd_tag2,
  output logic                          res_valid,
  output logic                          res_taken,
  output logic                          res_mispredict,
  output wb_pkg::xlen_t                 res_target,
  output wb_pkg::xlen_t                 res_link,
  output wb_pkg::tag_t                  res_dest_tag,
  output logic [br_pkg::INST_NUM_W-1:0] res_inst_num
);

  logic          taken_c;
  logic          mispredict_c;
  wb_pkg::xlen_t reg_sum_c;
  wb_pkg::xlen_t target_c;
  wb_pkg::xlen_t link_c;

  // operand read straight from the issue record
  assign rd_tag1 = issue.src1_tag;
  assign rd_tag2 = issue.src2_tag;

  always_comb begin
    case (issue.op)
      br_pkg::OP_BEQ:  taken_c = (rs1_data == rs2_data);
      br_pkg::OP_BNE:  taken_c = (rs1_data != rs2_data);
      br_pkg::OP_BLT:  taken_c = ($signed(rs1_data) < $signed(rs2_data));
      br_pkg::OP_BGE:  taken_c = ($signed(rs1_data) >= $signed(rs2_data));
      br_pkg::OP_BLTU: taken_c = (rs1_data < rs2_data);
      br_pkg::OP_BGEU: taken_c = (rs1_data >= rs2_data);
      default:         taken_c = 1'b1;  // jal, jalr
    endcase
  end

  assign reg_sum_c = rs1_data + issue.imm;
  assign target_c  = (issue.op == br_pkg::OP_JALR) ? {reg_sum_c[wb_pkg::XLEN-1:1], 1'b0}
                                                   : issue.pc + issue.imm;
  assign link_c    = issue.pc + wb_pkg::XLEN'(4);

  // wrong direction, or taken with no btb target to fetch from
  assign mispredict_c = (taken_c != issue.pred_taken) || (taken_c && !issue.pred_hit);

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid      <= 1'b0;
      res_mispredict <= 1'b0;
    end else begin
      res_valid      <= issue.valid;
      res_mispredict <= issue.valid && mispredict_c;
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      res_taken    <= taken_c;
      res_target   <= target_c;
      res_link     <= link_c;
      res_dest_tag <= issue.dest_tag;
      res_inst_num <= issue.inst_num;
    end
  end

endmodule

//--- hw/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile #(
  parameter int NUM_WB = 3
) (
  input  logic                       clk,
  input  logic [NUM_WB-1:0]          wb_valid,
  input  wb_pkg::tag_t [NUM_WB-1:0]  wb_tag,
  input  wb_pkg::xlen_t [NUM_WB-1:0] wb_data,
  input  wb_pkg::tag_t               rd_tag1,
  input  wb_pkg::tag_t               rd_tag2,
  output wb_pkg::xlen_t              rd_data1,
  output wb_pkg::xlen_t              rd_data2
);

  wb_pkg::xlen_t regs_q [wb_pkg::NUM_PREGS];

  // later lanes overwrite earlier ones on a tag clash
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WB; w++) begin
      if (wb_valid[w]) regs_q[wb_tag[w]] <= wb_data[w];
    end
  end

  assign rd_data1 = regs_q[rd_tag1];
  assign rd_data2 = regs_q[rd_tag2];

endmodule

//--- hw/branch_rs/branch_rs.sv
`timescale 1ns/1ps

module branch_rs #(
  parameter int DEPTH  = 16,
  parameter int NUM_WB = 3
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          clear,       // flush or mispredict
  input  logic                          disp_valid,
  input  logic [br_pkg::OP_W-1:0]       disp_op,
  input  wb_pkg::xlen_t                 disp_pc,
  input  wb_pkg::xlen_t                 disp_imm,
  input  wb_pkg::tag_t                  disp_src1_tag,
  input  wb_pkg::tag_t                  disp_src2_tag,
  input  logic                          disp_src1_rdy,
  input  logic                          disp_src2_rdy,
  input  wb_pkg::tag_t                  disp_dest_tag,
  input  logic                          disp_pred_taken,
  input  logic                          disp_pred_hit,
  input  logic [br_pkg::INST_NUM_W-1:0] disp_inst_num,
  input  logic [NUM_WB-1:0]             wb_valid,
  input  wb_pkg::tag_t [NUM_WB-1:0]     wb_tag,
  output logic                          full,
  br_issue_if.station                   issue
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  br_pkg::br_entry_t        entry_q [DEPTH];
  wb_pkg::tag_t [DEPTH-1:0] src1_tag_q;
  wb_pkg::tag_t [DEPTH-1:0] src2_tag_q;
  logic [DEPTH-1:0]         rdy1_q;
  logic [DEPTH-1:0]         rdy2_q;

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;

  logic [DEPTH-1:0] entry_wake1;
  logic [DEPTH-1:0] entry_wake2;
  logic             disp_wake1;
  logic             disp_wake2;
  logic             disp_accept;
  logic             head_ready;

  // registered issue stage
  logic              issue_valid_q;
  br_pkg::br_entry_t issue_entry_q;
  wb_pkg::tag_t      issue_src1_q;
  wb_pkg::tag_t      issue_src2_q;

  tag_wakeup #(
    .DEPTH  (DEPTH),
    .NUM_WB (NUM_WB)
  ) i_tag_wakeup (
    .entry_src1_tag (src1_tag_q),
    .entry_src2_tag (src2_tag_q),
    .disp_src1_tag  (disp_src1_tag),
    .disp_src2_tag  (disp_src2_tag),
    .wb_valid       (wb_valid),
    .wb_tag         (wb_tag),
    .entry_wake1    (entry_wake1),
    .entry_wake2    (entry_wake2),
    .disp_wake1     (disp_wake1),
    .disp_wake2     (disp_wake2)
  );

  assign full        = (count_q == CNT_W'(DEPTH));
  assign disp_accept = disp_valid && !full;
  // in order, only the oldest entry may go
  assign head_ready  = (count_q != '0) && rdy1_q[head_q] && rdy2_q[head_q];

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      head_q        <= '0;
      tail_q        <= '0;
      count_q       <= '0;
      issue_valid_q <= 1'b0;
    end else begin
      if (disp_accept) tail_q <= tail_q + 1'b1;  // wraps, DEPTH is 2**n
      if (head_ready) head_q <= head_q + 1'b1;
      count_q       <= count_q + CNT_W'(disp_accept) - CNT_W'(head_ready);
      issue_valid_q <= head_ready;
    end
  end

  always_ff @(posedge clk) begin
    for (int e = 0; e < DEPTH; e++) begin
      if (entry_wake1[e]) rdy1_q[e] <= 1'b1;
      if (entry_wake2[e]) rdy2_q[e] <= 1'b1;
    end
    if (disp_accept) begin
      entry_q[tail_q] <= '{
        op:         br_pkg::br_op_e'(disp_op),
        pc:         disp_pc,
        imm:        disp_imm,
        dest_tag:   disp_dest_tag,
        pred_taken: disp_pred_taken,
        pred_hit:   disp_pred_hit,
        inst_num:   disp_inst_num
      };
      src1_tag_q[tail_q] <= disp_src1_tag;
      src2_tag_q[tail_q] <= disp_src2_tag;
      rdy1_q[tail_q]     <= disp_src1_rdy | disp_wake1;  // same-cycle bypass
      rdy2_q[tail_q]     <= disp_src2_rdy | disp_wake2;
    end
    if (head_ready) begin
      issue_entry_q <= entry_q[head_q];
      issue_src1_q  <= src1_tag_q[head_q];
      issue_src2_q  <= src2_tag_q[head_q];
    end
  end

  // younger entries are wrong path once clear is up
  assign issue.valid      = issue_valid_q && !clear;
  assign issue.op         = issue_entry_q.op;
  assign issue.pc         = issue_entry_q.pc;
  assign issue.imm        = issue_entry_q.imm;
  assign issue.src1_tag   = issue_src1_q;
  assign issue.src2_tag   = issue_src2_q;
  assign issue.dest_tag   = issue_entry_q.dest_tag;
  assign issue.pred_taken = issue_entry_q.pred_taken;
  assign issue.pred_hit   = issue_entry_q.pred_hit;
  assign issue.inst_num   = issue_entry_q.inst_num;

endmodule

//--- hw/branch_rs/tag_wakeup.sv
`timescale 1ns/1ps

module tag_wakeup #(
  parameter int DEPTH  = 16,
  parameter int NUM_WB = 3
) (
  input  wb_pkg::tag_t [DEPTH-1:0]  entry_src1_tag,
  input  wb_pkg::tag_t [DEPTH-1:0]  entry_src2_tag,
  input  wb_pkg::tag_t              disp_src1_tag,
  input  wb_pkg::tag_t              disp_src2_tag,
  input  logic [NUM_WB-1:0]         wb_valid,
  input  wb_pkg::tag_t [NUM_WB-1:0] wb_tag,
  output logic [DEPTH-1:0]          entry_wake1,
  output logic [DEPTH-1:0]          entry_wake2,
  output logic                      disp_wake1,
  output logic                      disp_wake2
);

  // true when any valid lane broadcasts this tag
  function automatic logic tag_hit(input wb_pkg::tag_t tag);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < NUM_WB; w++) begin
      if (wb_valid[w] && (wb_tag[w] == tag)) hit = 1'b1;
    end
    return hit;
  endfunction

  always_comb begin
    for (int e = 0; e < DEPTH; e++) begin
      entry_wake1[e] = tag_hit(entry_src1_tag[e]);
      entry_wake2[e] = tag_hit(entry_src2_tag[e]);
    end
  end

  // bypass for the operation being dispatched this cycle
  assign disp_wake1 = tag_hit(disp_src1_tag);
  assign disp_wake2 = tag_hit(disp_src2_tag);

endmodule

//--- common/br_issue_if.sv
`timescale 1ns/1ps

interface br_issue_if;

  logic                          valid;       // one pulse per issued entry
  br_pkg::br_op_e                op;
  wb_pkg::xlen_t                 pc;
  wb_pkg::xlen_t                 imm;
  wb_pkg::tag_t                  src1_tag;
  wb_pkg::tag_t                  src2_tag;
  wb_pkg::tag_t                  dest_tag;
  logic                          pred_taken;
  logic                          pred_hit;
  logic [br_pkg::INST_NUM_W-1:0] inst_num;

  modport station (
    output valid, op, pc, imm, src1_tag, src2_tag, dest_tag,
           pred_taken, pred_hit, inst_num
  );

  modport resolver (
    input valid, op, pc, imm, src1_tag, src2_tag, dest_tag,
          pred_taken, pred_hit, inst_num
  );

endinterface

//--- common/br_pkg.sv
package br_pkg;

  localparam int OP_W       = 3;
  localparam int INST_NUM_W = 32;

  // conditional encodings follow funct3, jumps sit in the unused 010/011 slots
  typedef enum logic [OP_W-1:0] {
    OP_BEQ  = 3'b000,
    OP_BNE  = 3'b001,
    OP_JAL  = 3'b010,  // direct jump
    OP_JALR = 3'b011,  // register jump
    OP_BLT  = 3'b100,
    OP_BGE  = 3'b101,
    OP_BLTU = 3'b110,
    OP_BGEU = 3'b111
  } br_op_e;

  // payload kept per station entry and forwarded at issue
  typedef struct packed {
    br_op_e                  op;
    wb_pkg::xlen_t           pc;
    wb_pkg::xlen_t           imm;
    wb_pkg::tag_t            dest_tag;
    logic                    pred_taken;
    logic                    pred_hit;
    logic [INST_NUM_W-1:0]   inst_num;
  } br_entry_t;

endpackage

//--- common/wb_pkg.sv
package wb_pkg;

  localparam int TAG_W     = 6;   // 64 physical registers
  localparam int XLEN      = 32;
  localparam int NUM_PREGS = 64;  // register file depth, 2**TAG_W

  // physical register tag
  typedef logic [TAG_W-1:0] tag_t;

  // one data word as carried on a broadcast lane
  typedef logic [XLEN-1:0] xlen_t;

endpackage
